/* hdl/rv_pkg.sv */
package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int reg_count  = 32;

    // major opcodes
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;

    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // sub and sra
    localparam logic [6:0] f7_alt = 7'b0100000;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } i_type_t;

    typedef struct packed {
        logic [19:0]           imm;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } u_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        u_type_t u;
    } inst_word_u;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_e;

    typedef struct packed {
        logic                  valid;
        alu_op_e               alu_op;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       op_a;
        logic [xlen-1:0]       op_b;
    } ex_op_t;

    typedef struct packed {
        logic                  valid;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
    } wb_res_t;

endpackage

/* hdl/rv_regfile.sv */
module rv_regfile (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [rv_pkg::reg_addr_w-1:0] rs1_addr,
    input  logic [rv_pkg::reg_addr_w-1:0] rs2_addr,
    output logic [rv_pkg::xlen-1:0]       rs1_data,
    output logic [rv_pkg::xlen-1:0]       rs2_data,
    input  rv_pkg::wb_res_t               wb
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [reg_count];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int n = 0; n < reg_count; n++) begin
                regs[n] <= '0;
            end
        end else if (wb.valid && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // x0 reads as zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

/* hdl/rv_decode.sv */
module rv_decode (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          inst_valid,
    input  rv_pkg::inst_word_u            inst,
    output logic [rv_pkg::reg_addr_w-1:0] rs1_addr,
    output logic [rv_pkg::reg_addr_w-1:0] rs2_addr,
    input  logic [rv_pkg::xlen-1:0]       rs1_data,
    input  logic [rv_pkg::xlen-1:0]       rs2_data,
    input  rv_pkg::wb_res_t               ex_result,
    input  rv_pkg::wb_res_t               wb,
    output rv_pkg::ex_op_t                ex_op
);
    import rv_pkg::*;

    inst_word_u      inst_q;
    logic            inst_vld_q;
    logic            legal;
    logic            f7_zero;
    logic            f7_is_alt;
    alu_op_e         alu_op;
    logic [xlen-1:0] fwd_a;
    logic [xlen-1:0] fwd_b;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;

    // newest producer wins, x0 is never forwarded
    function automatic logic [xlen-1:0] fwd_sel(
        input logic [reg_addr_w-1:0] addr,
        input logic [xlen-1:0]       rf_data,
        input wb_res_t               ex_r,
        input wb_res_t               wb_r
    );
        logic [xlen-1:0] val;
        if (ex_r.valid && ex_r.rd != '0 && ex_r.rd == addr) begin
            val = ex_r.data;
        end else if (wb_r.valid && wb_r.rd != '0 && wb_r.rd == addr) begin
            val = wb_r.data;
        end else begin
            val = rf_data;
        end
        return val;
    endfunction

    assign rs1_addr = inst_q.r.rs1;
    assign rs2_addr = inst_q.r.rs2;

    assign fwd_a = fwd_sel(rs1_addr, rs1_data, ex_result, wb);
    assign fwd_b = fwd_sel(rs2_addr, rs2_data, ex_result, wb);

    // upper bits of the i-type immediate double as funct7
    assign f7_zero   = (inst_q.r.funct7 == '0);
    assign f7_is_alt = (inst_q.r.funct7 == f7_alt);

    always_comb begin
        legal = 1'b0;
        op_a  = fwd_a;
        op_b  = fwd_b;
        case (inst_q.r.funct3)
            f3_add:  alu_op = alu_add;
            f3_sll:  alu_op = alu_sll;
            f3_slt:  alu_op = alu_slt;
            f3_sltu: alu_op = alu_sltu;
            f3_xor:  alu_op = alu_xor;
            f3_sr:   alu_op = f7_is_alt ? alu_sra : alu_srl;
            f3_or:   alu_op = alu_or;
            default: alu_op = alu_and;
        endcase
        case (inst_q.r.opcode)
            opc_op: begin
                legal = f7_zero ||
                        (f7_is_alt && (inst_q.r.funct3 == f3_add || inst_q.r.funct3 == f3_sr));
                if (inst_q.r.funct3 == f3_add && f7_is_alt) begin
                    alu_op = alu_sub;
                end
            end
            opc_op_imm: begin
                if (inst_q.i.funct3 == f3_sll || inst_q.i.funct3 == f3_sr) begin
                    // shamt sits in the rs2 field
                    legal = f7_zero || (f7_is_alt && inst_q.i.funct3 == f3_sr);
                    op_b  = {{(xlen-reg_addr_w){1'b0}}, inst_q.r.rs2};
                end else begin
                    legal = 1'b1;
                    op_b  = {{(xlen-12){inst_q.i.imm[11]}}, inst_q.i.imm};
                end
            end
            opc_lui: begin
                legal  = 1'b1;
                alu_op = alu_pass_b;
                op_a   = '0;
                op_b   = {inst_q.u.imm, 12'b0};
            end
            default: legal = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            inst_q     <= '0;
            inst_vld_q <= 1'b0;
            ex_op      <= '0;
        end else begin
            inst_q       <= inst;
            inst_vld_q   <= inst_valid;
            // unsupported words still take a slot but never retire
            ex_op.valid  <= inst_vld_q && legal;
            ex_op.alu_op <= alu_op;
            ex_op.rd     <= inst_q.r.rd;
            ex_op.op_a   <= op_a;
            ex_op.op_b   <= op_b;
        end
    end

endmodule

/* hdl/rv_execute.sv */
module rv_execute (
    input  logic            clk,
    input  logic            rst_n,
    input  rv_pkg::ex_op_t  ex_op,
    output rv_pkg::wb_res_t ex_result,
    output rv_pkg::wb_res_t wb
);
    import rv_pkg::*;

    logic [xlen-1:0] alu_out;
    logic [4:0]      shamt;

    assign shamt = ex_op.op_b[4:0];

    always_comb begin
        case (ex_op.alu_op)
            alu_add: begin
                alu_out = ex_op.op_a + ex_op.op_b;
            end
            alu_sub: begin
                alu_out = ex_op.op_a - ex_op.op_b;
            end
            alu_sll: begin
                alu_out = ex_op.op_a << shamt;
            end
            alu_slt: begin
                alu_out = {{(xlen-1){1'b0}},
                           $signed(ex_op.op_a) < $signed(ex_op.op_b)};
            end
            alu_sltu: begin
                alu_out = {{(xlen-1){1'b0}}, ex_op.op_a < ex_op.op_b};
            end
            alu_xor: begin
                alu_out = ex_op.op_a ^ ex_op.op_b;
            end
            alu_srl: begin
                alu_out = ex_op.op_a >> shamt;
            end
            alu_sra: begin
                // arithmetic shift keeps the sign bit
                alu_out = $unsigned($signed(ex_op.op_a) >>> shamt);
            end
            alu_or: begin
                alu_out = ex_op.op_a | ex_op.op_b;
            end
            alu_and: begin
                alu_out = ex_op.op_a & ex_op.op_b;
            end
            alu_pass_b: begin
                alu_out = ex_op.op_b;
            end
            default: begin
                alu_out = '0;
            end
        endcase
    end

    // offered to decode in the same cycle for forwarding
    always_comb begin
        ex_result.valid = ex_op.valid;
        ex_result.rd    = ex_op.rd;
        ex_result.data  = alu_out;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb <= '0;
        end else begin
            wb <= ex_result;
        end
    end

endmodule

/* hdl/rv_core.sv */
module rv_core (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               inst_valid,
    input  rv_pkg::inst_word_u inst,
    output rv_pkg::wb_res_t    retire
);
    import rv_pkg::*;

    logic [reg_addr_w-1:0] rs1_addr;
    logic [reg_addr_w-1:0] rs2_addr;
    logic [xlen-1:0]       rs1_data;
    logic [xlen-1:0]       rs2_data;
    ex_op_t                ex_op;
    wb_res_t               ex_result;
    wb_res_t               wb;

    rv_decode u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .ex_result  (ex_result),
        .wb         (wb),
        .ex_op      (ex_op)
    );

    rv_execute u_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .ex_op     (ex_op),
        .ex_result (ex_result),
        .wb        (wb)
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb)
    );

    // the writeback register is the retire port
    assign retire = wb;

endmodule

/* tb/rv_core_chk.sv */
module rv_core_chk (
    input logic            clk,
    input logic            rst_n,
    input logic            inst_valid,
    input rv_pkg::wb_res_t retire
);
    timeunit 1ns;
    timeprecision 100ps;

    // reset flushes the pipeline
    retire_low_after_reset: assert property (@(posedge clk) !rst_n |=> !retire.valid)
        else $error("retire.valid high in the cycle after reset");

    // three stages between sampling and retire
    retire_has_source: assert property (@(posedge clk) disable iff (!rst_n)
        retire.valid |-> $past(inst_valid, 3))
        else $error("retire.valid without inst_valid three cycles earlier");

    retire_data_known: assert property (@(posedge clk) disable iff (!rst_n)
        retire.valid |-> !$isunknown(retire.data))
        else $error("retire.data has unknown bits while retire.valid is high");

endmodule

bind rv_core rv_core_chk u_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_valid (inst_valid),
    .retire     (retire)
);

/* tb/rv_core_tb.sv */
module rv_core_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import rv_pkg::*;

    localparam int n_directed = 40;
    localparam int n_random   = 150;
    // each word may be followed by up to three idle cycles
    localparam int max_cycles = 4 * (n_directed + n_random) + 60;

    logic       clk = 1'b0;
    logic       rst_n = 1'b0;
    logic       inst_valid = 1'b0;
    inst_word_u inst = '0;
    wb_res_t    retire;

    logic [reg_count-1:0][xlen-1:0] model_regs = '0;
    logic [15:0] lfsr_state = 16'd31;
    string       test_name = "reset";
    int          cycle = 0;
    int          issued = 0;
    int          retired = 0;
    wb_res_t     exp_q[$];
    int          due_q[$];
    string       name_q[$];

    rv_core UUT (.clk(clk), .rst_n(rst_n), .inst_valid(inst_valid), .inst(inst), .retire(retire));

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // fibonacci lfsr, taps 16 14 13 11
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = {lfsr_state[14:0],
                          lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, opc_op_imm};
    endfunction

    // architectural result of one word, in program order
    function automatic wb_res_t ref_model(inout logic [reg_count-1:0][xlen-1:0] regs,
                                          input logic [31:0] w);
        wb_res_t         res;
        logic            alt = (w[31:25] == f7_alt);
        logic            f7_zero = (w[31:25] == 7'd0);
        logic            is_sr = (w[14:12] == f3_sr);
        logic [xlen-1:0] a = regs[w[19:15]];
        logic [xlen-1:0] b = (w[6:0] == opc_op) ? regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
        case (w[6:0])
            opc_op:     res.valid = f7_zero || (alt && (w[14:12] == f3_add || is_sr));
            opc_op_imm: res.valid = !(is_sr || w[14:12] == f3_sll) || f7_zero || (alt && is_sr);
            default:    res.valid = (w[6:0] == opc_lui);
        endcase
        res.rd = w[11:7];
        case (w[14:12])
            f3_add:  res.data = (alt && w[6:0] == opc_op) ? a - b : a + b;
            f3_sll:  res.data = a << b[4:0];
            // differing signs decide a signed compare
            f3_slt:  res.data = {31'd0, (a[31] != b[31]) ? a[31] : (a < b)};
            f3_sltu: res.data = {31'd0, a < b};
            f3_xor:  res.data = a ^ b;
            f3_sr:   res.data = (a >> b[4:0]) | ((alt && a[31]) ? ~({xlen{1'b1}} >> b[4:0]) : '0);
            f3_or:   res.data = a | b;
            default: res.data = a & b;
        endcase
        if (w[6:0] == opc_lui) begin
            res.data = {w[31:12], 12'h000};
        end
        if (res.valid && res.rd != 5'd0) begin
            regs[res.rd] = res.data;
        end
        return res;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_retire(input string name, input wb_res_t exp, input wb_res_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERROR %s: expected rd=%0d data=%h, actual rd=%0d data=%h",
                                name, exp.rd, exp.data, act.rd, act.data));
        end
    endtask

    task automatic check_count(input int exp, input int act);
        if (act != exp) begin
            abort_run($sformatf("ERROR retire_count: expected %0d, actual %0d", exp, act));
        end
    endtask

    task automatic issue(input logic [31:0] w);
        wb_res_t res;
        @(posedge clk);
        #1;
        inst_valid = 1'b1;
        inst       = w;
        res        = ref_model(model_regs, w);
        if (res.valid) begin
            exp_q.push_back(res);
            due_q.push_back(cycle + 3);
            name_q.push_back(test_name);
            issued++;
        end
    endtask

    // idle cycles carry a random word that must be ignored
    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            inst_valid = 1'b0;
            inst       = rand_bits(32);
        end
    endtask

    always @(negedge clk) begin
        int    due;
        string name;
        if (retire.valid) begin
            if (exp_q.size() == 0) begin
                abort_run("a retire appeared with no supported instruction outstanding");
            end else begin
                due  = due_q.pop_front();
                name = name_q.pop_front();
                check_retire(name, exp_q.pop_front(), retire);
                if (cycle != due) begin
                    abort_run($sformatf("ERROR %s_timing: expected cycle %0d, actual cycle %0d",
                                        name, due, cycle));
                end
                retired++;
            end
        end
    end

    initial begin
        #(max_cycles * 10);
        abort_run("watchdog expired before the test sequence finished");
    end

    initial begin
        logic [4:0] rd;
        logic [2:0] f3;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        idle(4);
        test_name = "reg_imm";
        issue(enc_i(12'hffb, 5'd0, f3_add, 5'd1));
        issue(enc_i(12'd100, 5'd0, f3_add, 5'd2));
        issue({20'h80000, 5'd3, opc_lui});
        issue(enc_i(12'hfff, 5'd1, f3_slt, 5'd4));
        issue(enc_i(12'hfff, 5'd1, f3_sltu, 5'd5));
        issue(enc_i(12'h8f0, 5'd2, f3_xor, 5'd6));
        issue(enc_i({f7_alt, 5'd31}, 5'd3, f3_sr, 5'd7));
        issue(enc_i({7'd0, 5'd31}, 5'd3, f3_sr, 5'd4));
        issue(enc_i({f7_alt, 5'd0}, 5'd1, f3_sr, 5'd5));
        issue(enc_i({7'd0, 5'd31}, 5'd1, f3_sll, 5'd6));
        issue(enc_i({7'd0, 5'd0}, 5'd1, f3_sll, 5'd4));
        issue(enc_i({7'd0, 5'd0}, 5'd1, f3_sr, 5'd5));
        test_name = "reg_reg";
        issue(enc_i(12'd31, 5'd0, f3_add, 5'd7));
        issue(enc_r(f7_alt, 5'd2, 5'd1, f3_add, 5'd4));
        issue(enc_r(f7_alt, 5'd7, 5'd3, f3_sr, 5'd5));
        issue(enc_r(7'd0, 5'd7, 5'd3, f3_sr, 5'd6));
        issue(enc_r(7'd0, 5'd2, 5'd1, f3_slt, 5'd4));
        issue(enc_r(7'd0, 5'd2, 5'd1, f3_sltu, 5'd5));
        test_name = "forwarding";
        issue(enc_i(12'd7, 5'd0, f3_add, 5'd1));
        issue(enc_r(7'd0, 5'd1, 5'd1, f3_add, 5'd2));
        issue(enc_r(f7_alt, 5'd1, 5'd2, f3_add, 5'd3));
        issue(enc_r(7'd0, 5'd3, 5'd1, f3_xor, 5'd4));
        issue(enc_r(7'd0, 5'd4, 5'd2, f3_and, 5'd5));
        repeat (3) begin
            issue(enc_i(12'd1, 5'd1, f3_add, 5'd1));
        end
        test_name = "x0_write";
        issue(enc_i(12'd55, 5'd0, f3_add, 5'd0));
        issue(enc_r(7'd0, 5'd0, 5'd0, f3_add, 5'd1));
        issue(enc_r(7'd0, 5'd0, 5'd2, f3_or, 5'd3));
        test_name = "bad_words";
        issue(32'h0000_2083);
        idle(2);
        issue(enc_i(12'd9, 5'd1, f3_add, 5'd2));
        issue(enc_r(7'h01, 5'd2, 5'd1, f3_add, 5'd3));
        issue(enc_i({f7_alt, 5'd3}, 5'd2, f3_sll, 5'd4));
        issue(32'h0000_00ef);
        issue(enc_r(7'd0, 5'd2, 5'd3, f3_add, 5'd5));
        test_name = "random";
        for (int n = 0; n < n_random; n++) begin
            rd = 5'(rand_bits(3));
            f3 = 3'(rand_bits(3));
            case (rand_bits(2))
                2'd0: issue(enc_r(rand_bits(1) ? f7_alt : 7'd0, 5'(rand_bits(3)),
                                  5'(rand_bits(3)), f3, rd));
                2'd1: issue(enc_i(12'(rand_bits(12)), 5'(rand_bits(3)), f3, rd));
                2'd2: issue(enc_i({rand_bits(1) ? f7_alt : 7'd0, 5'(rand_bits(5))},
                                  5'(rand_bits(3)), f3, rd));
                default: issue(rand_bits(1) ? {20'(rand_bits(20)), rd, opc_lui} : rand_bits(32));
            endcase
            if (rand_bits(2) == 0) begin
                idle(int'(rand_bits(2)));
            end
        end
        idle(6);
        check_count(issued, retired);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* build.f */
hdl/rv_pkg.sv
hdl/rv_regfile.sv
hdl/rv_decode.sv
hdl/rv_execute.sv
hdl/rv_core.sv
tb/rv_core_chk.sv
tb/rv_core_tb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module rv_core_tb \
    -f build.f -o rv_core_sim &&
./obj_dir/rv_core_sim ||
{ echo "simulation failed"; exit 1; }
